// ==== csd_seq_pkg.sv ====
// Shared definitions for the measurement sequencer.
// The sequencer walks through idle, internal clear, measure reset and work,
// and a free-running scan counter produces the digital pulse.
package csd_seq_pkg;

    // Measurement sequencer states.
    // The encoding is binary, and the outputs are decoded from it.
    typedef enum logic [1:0]
    {
        // Waiting for sync enable.
        SEQ_IDLE       = 2'd0,
        // One cycle that clears the prescaler and the PRS.
        SEQ_CLEAR      = 2'd1,
        // Holds the measurement reset until measure enable arrives.
        SEQ_MEAS_RESET = 2'd2,
        // Channels may start while sync enable stays high.
        SEQ_WORK       = 2'd3
    } seq_state_e;

    // Width of the scan-rate counter.
    // It is wider than the period needs, which leaves room to slow the scan.
    localparam int SCAN_WIDTH = 7;

    // Reload value of the scan counter.
    // With a reload of 31 the counter passes 0 once every 32 cycles.
    localparam logic [SCAN_WIDTH-1:0] SCAN_PERIOD = 7'd31;

endpackage

// ==== csd_prs_pkg.sv ====
// Shared definitions for precharge clock generation.
// This covers the prescaler, the sliced PRS register and the source select.
package csd_prs_pkg;

    // Bits held by one PRS slice.
    localparam int SLICE_WIDTH = 8;

    // Number of slices chained to form the full register.
    localparam int PRS_SLICES = 2;

    // Full width of the PRS register.
    localparam int PRS_WIDTH = SLICE_WIDTH * PRS_SLICES;

    // Feedback taps of the Galois register.
    // The value is XORed in after the shift whenever the msb is one.
    localparam logic [PRS_WIDTH-1:0] PRS_POLY = 16'h002D;

    // The register restarts from all ones.
    // An all-zero value would lock the sequence, so the seed must be nonzero.
    localparam logic [PRS_WIDTH-1:0] PRS_SEED = {PRS_WIDTH{1'b1}};

    // Width of the prescaler count, its period and its compare value.
    localparam int PRESCALE_WIDTH = 8;

    // Selects what drives the precharge clock.
    typedef enum logic
    {
        // The prescaled compare level, a fixed-frequency clock.
        PCLK_PRESCALER = 1'b0,
        // The msb of the PRS register, a spread-spectrum bitstream.
        PCLK_PRS       = 1'b1
    } pclk_source_e;

endpackage

// ==== csd_sequencer.sv ====
`timescale 1ns/100ps

// Measurement sequencer and scan-rate counter.
// The control levels move the FSM, and the state decodes drive the
// internal clear, the measurement reset and the two channel starts.
module csd_sequencer
(
    input  logic op_clock,
    input  logic inter_reset,
    input  logic sync_en,
    input  logic meas_en,
    input  logic ch0_en,
    input  logic ch1_en,
    output logic seq_clear,
    output logic mesrst,
    output logic start0,
    output logic start1,
    output logic dpulse
);

    csd_seq_pkg::seq_state_e state;
    logic [csd_seq_pkg::SCAN_WIDTH-1:0] scan_count;

    // Each state waits for its own level input.
    // Only the clear state lasts a fixed single cycle.
    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            state <= csd_seq_pkg::SEQ_IDLE;
        end
        else
        begin
            case (state)
                csd_seq_pkg::SEQ_IDLE:
                begin
                    if (sync_en)
                    begin
                        state <= csd_seq_pkg::SEQ_CLEAR;
                    end
                end
                csd_seq_pkg::SEQ_CLEAR:
                begin
                    state <= csd_seq_pkg::SEQ_MEAS_RESET;
                end
                csd_seq_pkg::SEQ_MEAS_RESET:
                begin
                    if (meas_en)
                    begin
                        state <= csd_seq_pkg::SEQ_WORK;
                    end
                end
                default:
                begin
                    // Work ends as soon as sync enable drops.
                    if (!sync_en)
                    begin
                        state <= csd_seq_pkg::SEQ_IDLE;
                    end
                end
            endcase
        end
    end

    // The scan counter runs freely and is realigned by the internal clear.
    // Its reset value is the period, so dpulse stays low out of reset.
    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            scan_count <= csd_seq_pkg::SCAN_PERIOD;
        end
        else if (seq_clear || (scan_count == '0))
        begin
            scan_count <= csd_seq_pkg::SCAN_PERIOD;
        end
        else
        begin
            scan_count <= scan_count - 1'b1;
        end
    end

    // The digital pulse marks the terminal count.
    assign dpulse = (scan_count == '0);

    // State decodes.
    assign seq_clear = (state == csd_seq_pkg::SEQ_CLEAR);
    assign mesrst    = (state == csd_seq_pkg::SEQ_MEAS_RESET);
    assign start0    = (state == csd_seq_pkg::SEQ_WORK) && ch0_en;
    assign start1    = (state == csd_seq_pkg::SEQ_WORK) && ch1_en;

    // A channel must never start while the measurement reset is held.
    assert property (@(posedge op_clock) disable iff (inter_reset)
                     !(mesrst && start0))
        else $error("mesrst and start0 are high together");

endmodule

// ==== csd_prescaler.sv ====
`timescale 1ns/100ps

// Reload-and-decrement prescaler.
// The compare level forms the prescaled precharge clock, and an edge
// detector on that level steps the PRS register once per period.
module csd_prescaler
(
    input  logic                                  op_clock,
    input  logic                                  inter_reset,
    input  logic                                  seq_clear,
    input  logic [csd_prs_pkg::PRESCALE_WIDTH-1:0] prescale_period,
    input  logic [csd_prs_pkg::PRESCALE_WIDTH-1:0] prescale_compare,
    output logic                                  pre_level,
    output logic                                  prs_step
);

    logic [csd_prs_pkg::PRESCALE_WIDTH-1:0] count;
    logic                                   pre_level_dly;

    // The count runs from the period down to 0 and then reloads.
    // The level is high while the count sits at or below the compare value,
    // so the duty cycle follows the compare-to-period ratio.
    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            count         <= '0;
            pre_level     <= 1'b0;
            pre_level_dly <= 1'b0;
        end
        else if (seq_clear)
        begin
            count         <= prescale_period;
            pre_level     <= 1'b0;
            pre_level_dly <= 1'b0;
        end
        else
        begin
            if (count == '0)
            begin
                count <= prescale_period;
            end
            else
            begin
                count <= count - 1'b1;
            end
            pre_level     <= (count <= prescale_compare);
            pre_level_dly <= pre_level;
        end
    end

    // Rising edge of the level, registered once more.
    // The strobe lands one cycle after the level goes high.
    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            prs_step <= 1'b0;
        end
        else
        begin
            prs_step <= pre_level && !pre_level_dly;
        end
    end

    // One PRS advance per rising edge, so the strobe cannot repeat.
    assert property (@(posedge op_clock) disable iff (inter_reset)
                     prs_step |=> !prs_step)
        else $error("prs_step high on two consecutive cycles");

endmodule

// ==== prs_slice.sv ====
`timescale 1ns/100ps

// One slice of the Galois PRS register.
// Slices shift into each other through shift_in and msb, and all of them
// share the msb of the last slice as feedback.
module prs_slice
#(
    parameter int slice_index = 0
)
(
    input  logic op_clock,
    input  logic inter_reset,
    input  logic seq_clear,
    input  logic prs_step,
    input  logic shift_in,
    input  logic feedback,
    output logic msb
);

    logic [csd_prs_pkg::SLICE_WIDTH-1:0] value;
    logic [csd_prs_pkg::SLICE_WIDTH-1:0] poly_part;
    logic [csd_prs_pkg::SLICE_WIDTH-1:0] seed_part;

    // This slice's share of the taps and the seed.
    assign poly_part =
        csd_prs_pkg::PRS_POLY[slice_index*csd_prs_pkg::SLICE_WIDTH +: csd_prs_pkg::SLICE_WIDTH];
    assign seed_part =
        csd_prs_pkg::PRS_SEED[slice_index*csd_prs_pkg::SLICE_WIDTH +: csd_prs_pkg::SLICE_WIDTH];

    // Shift left on each step and fold in the taps when the feedback is set.
    // The clear reseeds the slice so every measurement sees the same sequence.
    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            value <= seed_part;
        end
        else if (seq_clear)
        begin
            value <= seed_part;
        end
        else if (prs_step)
        begin
            value <= {value[csd_prs_pkg::SLICE_WIDTH-2:0], shift_in}
                     ^ (feedback ? poly_part : '0);
        end
    end

    assign msb = value[csd_prs_pkg::SLICE_WIDTH-1];

endmodule

// ==== precharge_select.sv ====
`timescale 1ns/100ps

// Precharge output stage.
// The chosen source is registered so that switching the select does not
// glitch the precharge or shield pins.
module precharge_select
(
    input  logic                      op_clock,
    input  logic                      inter_reset,
    input  csd_prs_pkg::pclk_source_e pclk_source,
    input  logic                      pre_level,
    input  logic                      bitstream,
    output logic                      ppulse,
    output logic                      shield
);

    logic pclk_next;

    // Fixed clock or spread-spectrum bitstream.
    assign pclk_next = (pclk_source == csd_prs_pkg::PCLK_PRS) ? bitstream : pre_level;

    // The shield follows the precharge with source polarity.
    // Both come from the same flop input, so they switch on the same edge.
    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            ppulse <= 1'b0;
            shield <= 1'b0;
        end
        else
        begin
            ppulse <= pclk_next;
            shield <= pclk_next;
        end
    end

    // The shield must track the electrode drive on every cycle.
    assert property (@(posedge op_clock) disable iff (inter_reset) shield == ppulse)
        else $error("shield differs from ppulse");

endmodule

// ==== csd_clock_gen.sv ====
`timescale 1ns/100ps

// Clock generator of the capacitive-sensing front end.
// The sequencer drives the measurement control, the prescaler paces the PRS
// slices, and the output stage drives the precharge and shield pins.
module csd_clock_gen
(
    input  logic                                  op_clock,
    input  logic                                  inter_reset,
    input  logic                                  sync_en,
    input  logic                                  meas_en,
    input  logic                                  ch0_en,
    input  logic                                  ch1_en,
    input  csd_prs_pkg::pclk_source_e              pclk_source,
    input  logic [csd_prs_pkg::PRESCALE_WIDTH-1:0] prescale_period,
    input  logic [csd_prs_pkg::PRESCALE_WIDTH-1:0] prescale_compare,
    output logic                                  dpulse,
    output logic                                  ppulse,
    output logic                                  start0,
    output logic                                  start1,
    output logic                                  mesrst,
    output logic                                  shield
);

    logic seq_clear;
    logic pre_level;
    logic prs_step;

    // Shift chain through the slices.
    // Entry k feeds slice k, and slice k drives entry k+1.
    // The last entry is the msb of the whole register.
    logic [csd_prs_pkg::PRS_SLICES:0] prs_chain;

    csd_sequencer i_csd_sequencer
    (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .sync_en     (sync_en),
        .meas_en     (meas_en),
        .ch0_en      (ch0_en),
        .ch1_en      (ch1_en),
        .seq_clear   (seq_clear),
        .mesrst      (mesrst),
        .start0      (start0),
        .start1      (start1),
        .dpulse      (dpulse)
    );

    csd_prescaler i_csd_prescaler
    (
        .op_clock         (op_clock),
        .inter_reset      (inter_reset),
        .seq_clear        (seq_clear),
        .prescale_period  (prescale_period),
        .prescale_compare (prescale_compare),
        .pre_level        (pre_level),
        .prs_step         (prs_step)
    );

    // A zero shifts into the bottom of the register.
    assign prs_chain[0] = 1'b0;

    // The msb of the top slice feeds back into every slice.
    for (genvar k = 0; k < csd_prs_pkg::PRS_SLICES; k++)
    begin : g_slice
        prs_slice #(.slice_index(k)) i_prs_slice
        (
            .op_clock    (op_clock),
            .inter_reset (inter_reset),
            .seq_clear   (seq_clear),
            .prs_step    (prs_step),
            .shift_in    (prs_chain[k]),
            .feedback    (prs_chain[csd_prs_pkg::PRS_SLICES]),
            .msb         (prs_chain[k+1])
        );
    end

    precharge_select i_precharge_select
    (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .pclk_source (pclk_source),
        .pre_level   (pre_level),
        .bitstream   (prs_chain[csd_prs_pkg::PRS_SLICES]),
        .ppulse      (ppulse),
        .shield      (shield)
    );

endmodule

// ==== tb_csd_clock_gen.sv ====
`timescale 1ns/100ps

// Testbench for the capacitive-sensing clock generator.
// A cycle model of every register runs next to the DUT, and each output is
// compared with it shortly after every rising edge.
module tb_csd_clock_gen;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int PAIRS        = 4;
    localparam int PAIR_CYCLES  = 96;
    localparam int PRS_CYCLES   = 480;
    localparam int SWITCHES     = 4;
    localparam int SEQ_CYCLES   = 35;
    // Three dpulse searches, each bounded at 64 cycles.
    localparam int SCAN_CYCLES  = 1 + 3 * 64;
    localparam int RUN_CYCLES   = RESET_CYCLES + SEQ_CYCLES + SCAN_CYCLES + 1
                                  + (PAIRS + SWITCHES) * PAIR_CYCLES + 3 + 2 * PRS_CYCLES;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + 100;

    // Every register of the design, in one record.
    typedef struct packed
    {
        csd_seq_pkg::seq_state_e                 state;
        logic [csd_seq_pkg::SCAN_WIDTH-1:0]     scan;
        logic [csd_prs_pkg::PRESCALE_WIDTH-1:0] count;
        logic                                   level;
        logic                                   level_dly;
        logic                                   step;
        logic [csd_prs_pkg::PRS_WIDTH-1:0]      prs;
        logic                                   ppulse;
        logic                                   shield;
    } model_t;

    logic                                   op_clock;
    logic                                   inter_reset;
    logic                                   sync_en;
    logic                                   meas_en;
    logic                                   ch0_en;
    logic                                   ch1_en;
    csd_prs_pkg::pclk_source_e              pclk_source;
    logic [csd_prs_pkg::PRESCALE_WIDTH-1:0] prescale_period;
    logic [csd_prs_pkg::PRESCALE_WIDTH-1:0] prescale_compare;
    logic                                   dpulse;
    logic                                   ppulse;
    logic                                   start0;
    logic                                   start1;
    logic                                   mesrst;
    logic                                   shield;

    model_t      model;
    logic [15:0] lfsr_state;
    string       test_name;

    csd_clock_gen i_csd_clock_gen
    (
        .op_clock         (op_clock),
        .inter_reset      (inter_reset),
        .sync_en          (sync_en),
        .meas_en          (meas_en),
        .ch0_en           (ch0_en),
        .ch1_en           (ch1_en),
        .pclk_source      (pclk_source),
        .prescale_period  (prescale_period),
        .prescale_compare (prescale_compare),
        .dpulse           (dpulse),
        .ppulse           (ppulse),
        .start0           (start0),
        .start1           (start1),
        .mesrst           (mesrst),
        .shield           (shield)
    );

    always #(CLK_PERIOD / 2) op_clock = ~op_clock;

    // Register values right after the asynchronous reset.
    function automatic model_t reset_model();
        model_t m;
        m.state     = csd_seq_pkg::SEQ_IDLE;
        m.scan      = csd_seq_pkg::SCAN_PERIOD;
        m.count     = '0;
        m.level     = 1'b0;
        m.level_dly = 1'b0;
        m.step      = 1'b0;
        m.prs       = csd_prs_pkg::PRS_SEED;
        m.ppulse    = 1'b0;
        m.shield    = 1'b0;
        return m;
    endfunction

    // Advances the model by one rising edge.
    function automatic model_t next_model(input model_t m, input logic sync, input logic meas,
                                          input csd_prs_pkg::pclk_source_e src,
                                          input logic [7:0] per, input logic [7:0] cmp);
        model_t n;
        logic   clr;
        n   = m;
        clr = (m.state == csd_seq_pkg::SEQ_CLEAR);
        case (m.state)
            csd_seq_pkg::SEQ_IDLE:       n.state = sync ? csd_seq_pkg::SEQ_CLEAR : m.state;
            csd_seq_pkg::SEQ_CLEAR:      n.state = csd_seq_pkg::SEQ_MEAS_RESET;
            csd_seq_pkg::SEQ_MEAS_RESET: n.state = meas ? csd_seq_pkg::SEQ_WORK : m.state;
            default:                     n.state = sync ? m.state : csd_seq_pkg::SEQ_IDLE;
        endcase
        // The scan count wraps from 0 back to 31 and is realigned by the clear.
        n.scan = (clr || m.scan == '0) ? csd_seq_pkg::SCAN_PERIOD : m.scan - 7'd1;
        if (clr)
        begin
            n.count     = per;
            n.level     = 1'b0;
            n.level_dly = 1'b0;
        end
        else
        begin
            n.count     = (m.count == '0) ? per : m.count - 8'd1;
            n.level     = (m.count <= cmp);
            n.level_dly = m.level;
        end
        n.step = m.level && !m.level_dly;
        // Full-width Galois step, with a zero entering at the bottom.
        if (clr)
        begin
            n.prs = csd_prs_pkg::PRS_SEED;
        end
        else if (m.step)
        begin
            n.prs = {m.prs[csd_prs_pkg::PRS_WIDTH-2:0], 1'b0}
                    ^ (m.prs[csd_prs_pkg::PRS_WIDTH-1] ? csd_prs_pkg::PRS_POLY : 16'h0);
        end
        n.ppulse = (src == csd_prs_pkg::PCLK_PRS) ? m.prs[csd_prs_pkg::PRS_WIDTH-1] : m.level;
        n.shield = n.ppulse;
        return n;
    endfunction

    // Galois LFSR with taps 0xB400, one step per bit taken.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int count, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            bits       = {bits[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string sig, input logic exp, input logic act);
        assert (act === exp)
        else
        begin
            $display("MISMATCH test=%s signal=%s expected=%0b actual=%0b",
                     test_name, sig, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        assert (act == exp)
        else
        begin
            $display("MISMATCH test=%s check=%s expected=%0d actual=%0d",
                     test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic run_cycles(input int n);
        repeat (n) @(negedge op_clock);
    endtask

    task automatic pick_channels();
        logic [7:0] bits;
        take_bits(2, bits);
        ch0_en = bits[0];
        ch1_en = bits[1];
    endtask

    // Period from 1 to 15, compare below the period.
    task automatic pick_prescale();
        logic [7:0] bits;
        take_bits(4, bits);
        if (bits == 8'd0)
        begin
            bits = 8'd1;
        end
        prescale_period = bits;
        take_bits(4, bits);
        prescale_compare = bits % prescale_period;
    endtask

    // Called on the falling edge at which sync_en rises from idle.
    task automatic check_first_dpulse();
        int cycles;
        cycles = 0;
        // This edge enters the clear state.
        @(posedge op_clock);
        do
        begin
            @(posedge op_clock);
            #1;
            cycles++;
        end
        while (dpulse !== 1'b1 && cycles < 64);
        check_count("first dpulse after clear", 32, cycles);
    endtask

    task automatic check_dpulse_gap();
        int gap;
        gap = 0;
        do
        begin
            @(posedge op_clock);
            #1;
            gap++;
        end
        while (dpulse !== 1'b1 && gap < 64);
        check_count("dpulse period", 32, gap);
    endtask

    // The model follows the DUT's asynchronous reset.
    always @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            model = reset_model();
        end
        else
        begin
            model = next_model(model, sync_en, meas_en, pclk_source,
                               prescale_period, prescale_compare);
        end
    end

    // Outputs settle well before the next falling edge changes the inputs.
    always @(posedge op_clock)
    begin
        #1;
        check_bit("dpulse", model.scan == '0, dpulse);
        check_bit("mesrst", model.state == csd_seq_pkg::SEQ_MEAS_RESET, mesrst);
        check_bit("start0", (model.state == csd_seq_pkg::SEQ_WORK) && ch0_en, start0);
        check_bit("start1", (model.state == csd_seq_pkg::SEQ_WORK) && ch1_en, start1);
        check_bit("ppulse", model.ppulse, ppulse);
        check_bit("shield", model.shield, shield);
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run took longer than all tests together should take");
        abort_run();
    end

    initial
    begin
        logic [7:0] bits;
        op_clock         = 1'b0;
        inter_reset      = 1'b1;
        sync_en          = 1'b0;
        meas_en          = 1'b0;
        ch0_en           = 1'b0;
        ch1_en           = 1'b0;
        pclk_source      = csd_prs_pkg::PCLK_PRESCALER;
        prescale_period  = 8'd4;
        prescale_compare = 8'd1;
        lfsr_state       = 16'd2029;
        test_name        = "reset";
        run_cycles(RESET_CYCLES);
        inter_reset = 1'b0;
        run_cycles(3);

        // Walk the FSM by hand.
        test_name = "sequencer";
        pick_channels();
        sync_en = 1'b1;
        repeat (2) @(posedge op_clock);
        #1;
        check_bit("mesrst two cycles after sync_en", 1'b1, mesrst);
        run_cycles(6);
        meas_en = 1'b1;
        for (int i = 0; i < 4; i++)
        begin
            run_cycles(5);
            pick_channels();
        end
        sync_en = 1'b0;
        run_cycles(4);

        // Scan pulse spacing, counted from a fresh clear.
        test_name = "scan";
        sync_en = 1'b1;
        check_first_dpulse();
        check_dpulse_gap();
        check_dpulse_gap();
        run_cycles(1);

        test_name = "prescaler";
        for (int p = 0; p < PAIRS; p++)
        begin
            pick_prescale();
            run_cycles(PAIR_CYCLES);
        end

        test_name   = "prs";
        pclk_source = csd_prs_pkg::PCLK_PRS;
        pick_prescale();
        run_cycles(PRS_CYCLES);

        // The output register absorbs a source change at any cycle.
        test_name = "source_switch";
        for (int s = 0; s < SWITCHES; s++)
        begin
            take_bits(1, bits);
            pclk_source = csd_prs_pkg::pclk_source_e'(bits[0]);
            pick_prescale();
            run_cycles(PAIR_CYCLES);
        end

        // A restart reseeds the PRS, so the model restarts from the seed too.
        test_name   = "reseed";
        pclk_source = csd_prs_pkg::PCLK_PRS;
        sync_en     = 1'b0;
        run_cycles(3);
        sync_en = 1'b1;
        run_cycles(PRS_CYCLES);

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== flist.f ====
csd_seq_pkg.sv
csd_prs_pkg.sv
csd_sequencer.sv
csd_prescaler.sv
prs_slice.sv
precharge_select.sv
csd_clock_gen.sv
tb_csd_clock_gen.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is that of the simulation.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
    --top-module tb_csd_clock_gen \
    -f flist.f \
    -o sim_tb_csd_clock_gen
./obj_dir/sim_tb_csd_clock_gen
